/* project.f */
+incdir+rtl
rtl/queue_entry_pkg.sv
rtl/read_ctrl_pkg.sv
rtl/frame_ctrl_queue.sv
rtl/buf_size_acc.sv
rtl/buf_ctrl_queue.sv
rtl/playback_fsm.sv
rtl/read_addr_gen.sv
rtl/mem_read_ctrl.sv
testbench/tb_mem_read_ctrl.sv

/* rtl/buf_ctrl_queue.sv */
`timescale 1ns/10ps
`include "frame_read_params.svh"

module buf_ctrl_queue (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        wr_valid_i,
  input  queue_entry_pkg::bcq_desc_t  wr_desc_i,
  input  logic [`BSIZE_W-1:0]         size_i,
  output logic                        wr_ready_o,
  input  logic                        pop_i,
  output queue_entry_pkg::bcq_entry_t head_o,
  output logic                        not_empty_o
);

  localparam int PTR_W = $clog2(`BCQ_DEPTH);

  queue_entry_pkg::bcq_entry_t mem [`BCQ_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             do_wr;
  logic             do_rd;

  assign wr_ready_o  = (count != (PTR_W+1)'(`BCQ_DEPTH));
  assign not_empty_o = (count != '0);

  assign do_wr = wr_valid_i && wr_ready_o;
  assign do_rd = pop_i && not_empty_o;

  // ====================
  // Storage
  // ====================
  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= '{desc: wr_desc_i, size: size_i};
    end
  end

  // Head shows without a read request
  assign head_o = mem[rd_ptr];

  // ====================
  // Pointers
  // ====================
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous write and pop keeps the count
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* rtl/buf_size_acc.sv */
`timescale 1ns/10ps
`include "frame_read_params.svh"

module buf_size_acc (
  input  logic                     clk,
  input  logic                     rst,
  input  queue_entry_pkg::fcq_wr_t wr_i,
  input  logic [`FLEN_W-1:0]       old_len_i,
  input  logic                     capturing_i,
  input  logic                     buf_full_i,
  input  logic                     send_wr_i,
  output logic [`BSIZE_W-1:0]      size_o
);

  logic                capturing_d1;
  logic                capturing_re;
  logic [`BSIZE_W-1:0] new_len;
  logic [`BSIZE_W-1:0] old_len;

  // Capture start detect
  always_ff @(posedge clk) begin
    if (rst) begin
      capturing_d1 <= 1'b0;
    end else begin
      capturing_d1 <= capturing_i;
    end
  end

  assign capturing_re = capturing_i && !capturing_d1;

  assign new_len = `BSIZE_W'(wr_i.entry.frame_len);
  assign old_len = `BSIZE_W'(old_len_i);

  always_ff @(posedge clk) begin
    if (rst || send_wr_i || capturing_re) begin
      size_o <= '0;
    end else if (wr_i.valid) begin
      // Full ring, new frame replaces an old one
      if (buf_full_i && !capturing_i) begin
        size_o <= size_o + new_len - old_len;
      end else begin
        size_o <= size_o + new_len;
      end
    end
  end

endmodule

/* rtl/frame_ctrl_queue.sv */
`timescale 1ns/10ps
`include "frame_read_params.svh"

module frame_ctrl_queue (
  input  logic                        clk,
  input  logic                        rst,
  input  queue_entry_pkg::fcq_wr_t    wr_i,
  input  logic [`FNUM_W-1:0]          rd_fnum_i,
  output queue_entry_pkg::fcq_entry_t rd_entry_o,
  output logic [`FLEN_W-1:0]          old_len_o,
  output logic                        frm_avail_o
);

  localparam int FCQ_DEPTH = 1 << `FNUM_W;

  queue_entry_pkg::fcq_entry_t mem [FCQ_DEPTH];

  // ====================
  // Descriptor storage
  // ====================
  always_ff @(posedge clk) begin
    if (wr_i.valid) begin
      mem[wr_i.fnum] <= wr_i.entry;
    end
  end

  // Playback port, data one cycle after the frame number
  always_ff @(posedge clk) begin
    rd_entry_o <= mem[rd_fnum_i];
  end

  // Length being overwritten, read before the write lands
  assign old_len_o = mem[wr_i.fnum].frame_len;

  // ====================
  // Frame available
  // ====================
  always_ff @(posedge clk) begin
    if (rst) begin
      frm_avail_o <= 1'b0;
    end else if (wr_i.valid) begin
      // Tail write closes the buffer
      if (wr_i.entry.tail) begin
        frm_avail_o <= 1'b0;
      end else begin
        frm_avail_o <= 1'b1;
      end
    end
  end

endmodule

/* rtl/frame_read_params.svh */
`ifndef FRAME_READ_PARAMS_SVH
`define FRAME_READ_PARAMS_SVH

// ====================
// Field widths
// ====================
`define FNUM_W 9
`define ADDR_W 25
// Frame length in bytes, a frame holds length/4 words
`define FLEN_W 16
`define RPT_W 5
`define ZOOM_W 4
`define BSIZE_W 32

// ====================
// Memory and queue sizing
// ====================
// Words per read command
`define MEM_BL 8
`define BCQ_DEPTH 16
// Frame start addresses sit on 4 KB boundaries
`define ALIGN_BITS 12

`endif

/* rtl/mem_read_ctrl.sv */
`timescale 1ns/10ps
`include "frame_read_params.svh"

module mem_read_ctrl (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [`RPT_W-1:0]          rpt_rate_i,
  input  queue_entry_pkg::fcq_wr_t   fcq_wr_i,
  input  logic                       bcq_wr_valid_i,
  input  queue_entry_pkg::bcq_desc_t bcq_wr_desc_i,
  output logic                       bcq_wr_ready_o,
  input  logic                       capturing_i,
  input  logic                       buf_full_i,
  input  logic                       send_wr_i,
  input  logic                       disc_req_i,
  output logic                       disc_ack_o,
  input  logic                       mem_rd_cmd_i,
  input  logic                       mem_rd_vld_i,
  output logic                       frame_rdy_o,
  output logic [`ADDR_W-1:0]         rd_addr_o,
  output read_ctrl_pkg::rd_side_t    rd_side_o,
  output logic [`ZOOM_W-1:0]         zoom_o,
  output logic [`FLEN_W-1:0]         frame_len_o,
  output logic [`BSIZE_W-1:0]        buf_size_o,
  output logic                       buf_avail_o,
  output logic                       frm_avail_o,
  output logic                       rpl_done_o,
  output logic                       addr_err_o
);

  queue_entry_pkg::fcq_entry_t fcq_entry;
  queue_entry_pkg::bcq_entry_t bcq_head;

  logic [`FNUM_W-1:0]  fcq_fnum;
  logic [`FLEN_W-1:0]  old_len;
  logic [`BSIZE_W-1:0] acc_size;
  logic [2:0]          rd_type;
  logic                bcq_not_empty;
  logic                bcq_pop;
  logic                load;
  logic                sof;
  logic                eof;
  logic                sob;
  logic                eob;

  // ====================
  // Queues and size
  // ====================
  frame_ctrl_queue frame_ctrl_queue_inst (
    .clk(clk), .rst(rst), .wr_i(fcq_wr_i), .rd_fnum_i(fcq_fnum),
    .rd_entry_o(fcq_entry), .old_len_o(old_len), .frm_avail_o(frm_avail_o)
  );

  buf_size_acc buf_size_acc_inst (
    .clk(clk), .rst(rst), .wr_i(fcq_wr_i), .old_len_i(old_len),
    .capturing_i(capturing_i), .buf_full_i(buf_full_i),
    .send_wr_i(send_wr_i), .size_o(acc_size)
  );

  buf_ctrl_queue buf_ctrl_queue_inst (
    .clk(clk), .rst(rst), .wr_valid_i(bcq_wr_valid_i), .wr_desc_i(bcq_wr_desc_i),
    .size_i(acc_size), .wr_ready_o(bcq_wr_ready_o), .pop_i(bcq_pop),
    .head_o(bcq_head), .not_empty_o(bcq_not_empty)
  );

  // ====================
  // Playback and addressing
  // ====================
  playback_fsm playback_fsm_inst (
    .clk(clk), .rst(rst), .rpt_rate_i(rpt_rate_i), .bcq_head_i(bcq_head),
    .bcq_not_empty_i(bcq_not_empty), .fcq_entry_i(fcq_entry), .eof_i(eof),
    .sof_i(sof), .disc_req_i(disc_req_i), .fcq_fnum_o(fcq_fnum), .load_o(load),
    .bcq_pop_o(bcq_pop), .disc_ack_o(disc_ack_o), .frame_rdy_o(frame_rdy_o),
    .sob_o(sob), .eob_o(eob), .buf_avail_o(buf_avail_o), .rpl_done_o(rpl_done_o)
  );

  assign rd_type = {bcq_head.desc.video, bcq_head.desc.frame, bcq_head.desc.audio};

  read_addr_gen read_addr_gen_inst (
    .clk(clk), .rst(rst), .load_i(load), .entry_i(fcq_entry),
    .mem_rd_cmd_i(mem_rd_cmd_i), .mem_rd_vld_i(mem_rd_vld_i), .type_i(rd_type),
    .sof_o(sof), .eof_o(eof), .rd_addr_o(rd_addr_o), .type_o(rd_side_o[2:0]),
    .addr_err_o(addr_err_o)
  );

  // Word sideband, type flags come registered
  assign rd_side_o[6:3] = {sof, eof, sob, eob};

  assign zoom_o      = fcq_entry.zoom;
  assign frame_len_o = fcq_entry.frame_len;
  assign buf_size_o  = bcq_head.size;

endmodule

/* rtl/playback_fsm.sv */
`timescale 1ns/10ps
`include "frame_read_params.svh"

module playback_fsm (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [`RPT_W-1:0]           rpt_rate_i,
  input  queue_entry_pkg::bcq_entry_t bcq_head_i,
  input  logic                        bcq_not_empty_i,
  input  queue_entry_pkg::fcq_entry_t fcq_entry_i,
  input  logic                        eof_i,
  input  logic                        sof_i,
  input  logic                        disc_req_i,
  output logic [`FNUM_W-1:0]          fcq_fnum_o,
  output logic                        load_o,
  output logic                        bcq_pop_o,
  output logic                        disc_ack_o,
  output logic                        frame_rdy_o,
  output logic                        sob_o,
  output logic                        eob_o,
  output logic                        buf_avail_o,
  output logic                        rpl_done_o
);

  read_ctrl_pkg::play_state_e state;
  read_ctrl_pkg::play_state_e next_state;

  logic [`RPT_W-1:0] rpt_cnt;
  logic [`RPT_W:0]   rpt_rate_eff;
  logic              rpt_done;
  logic              read_eof;

  // Rate of zero plays each frame once
  assign rpt_rate_eff = (rpt_rate_i == '0) ? (`RPT_W+1)'(1) : {1'b0, rpt_rate_i};
  assign rpt_done     = ({1'b0, rpt_cnt} + 1'b1) >= rpt_rate_eff;

  // ====================
  // State machine
  // ====================
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= read_ctrl_pkg::IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      read_ctrl_pkg::IDLE: begin
        if (bcq_not_empty_i) begin
          next_state = read_ctrl_pkg::LOAD_HEAD;
        end
      end
      read_ctrl_pkg::LOAD_HEAD:  next_state = read_ctrl_pkg::RD_FCQ;
      read_ctrl_pkg::RD_FCQ:     next_state = read_ctrl_pkg::FCQ_AVAIL;
      read_ctrl_pkg::FCQ_AVAIL:  next_state = read_ctrl_pkg::RPT_DECIDE;
      read_ctrl_pkg::RPT_DECIDE: begin
        if (disc_req_i) begin
          next_state = read_ctrl_pkg::DISCARD;
        end else if (!rpt_done) begin
          next_state = read_ctrl_pkg::READ_REPEAT;
        end else if (fcq_entry_i.tail) begin
          next_state = read_ctrl_pkg::READ_LAST;
        end else if (fcq_entry_i.bottom) begin
          next_state = read_ctrl_pkg::READ_WRAP;
        end else begin
          next_state = read_ctrl_pkg::READ_NEXT;
        end
      end
      read_ctrl_pkg::READ_REPEAT,
      read_ctrl_pkg::READ_NEXT,
      read_ctrl_pkg::READ_WRAP: begin
        if (eof_i) begin
          next_state = read_ctrl_pkg::RD_FCQ;
        end
      end
      read_ctrl_pkg::READ_LAST: begin
        if (eof_i) begin
          next_state = read_ctrl_pkg::BUF_DONE;
        end
      end
      read_ctrl_pkg::BUF_DONE: begin
        if (disc_req_i) begin
          next_state = read_ctrl_pkg::DISCARD;
        end
      end
      read_ctrl_pkg::DISCARD:    next_state = read_ctrl_pkg::IDLE;
      default:                   next_state = read_ctrl_pkg::IDLE;
    endcase
  end

  assign frame_rdy_o = (state == read_ctrl_pkg::READ_REPEAT) ||
                       (state == read_ctrl_pkg::READ_NEXT)   ||
                       (state == read_ctrl_pkg::READ_WRAP)   ||
                       (state == read_ctrl_pkg::READ_LAST);
  assign read_eof    = frame_rdy_o && eof_i;
  assign load_o      = (state == read_ctrl_pkg::FCQ_AVAIL);
  assign disc_ack_o  = (state == read_ctrl_pkg::DISCARD);
  assign bcq_pop_o   = disc_ack_o;

  // ====================
  // Frame number and repeats
  // ====================
  always_ff @(posedge clk) begin
    if (rst) begin
      fcq_fnum_o <= '0;
    end else if (state == read_ctrl_pkg::LOAD_HEAD) begin
      fcq_fnum_o <= bcq_head_i.desc.head_fnum;
    end else if (read_eof && state == read_ctrl_pkg::READ_NEXT) begin
      fcq_fnum_o <= fcq_fnum_o + 1'b1;
    end else if (read_eof && state == read_ctrl_pkg::READ_WRAP) begin
      fcq_fnum_o <= bcq_head_i.desc.top_fnum;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || state == read_ctrl_pkg::DISCARD) begin
      rpt_cnt <= '0;
    end else if (read_eof) begin
      rpt_cnt <= rpt_done ? '0 : rpt_cnt + 1'b1;
    end
  end

  // Buffer boundaries
  assign sob_o = sof_i && (fcq_fnum_o == bcq_head_i.desc.head_fnum);
  assign eob_o = eof_i && (state == read_ctrl_pkg::READ_LAST);

  // ====================
  // Status
  // ====================
  always_ff @(posedge clk) begin
    if (rst || disc_ack_o) begin
      rpl_done_o <= 1'b0;
    end else if (eob_o) begin
      rpl_done_o <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || state == read_ctrl_pkg::IDLE) begin
      buf_avail_o <= 1'b0;
    end else if (state == read_ctrl_pkg::FCQ_AVAIL) begin
      buf_avail_o <= 1'b1;
    end
  end

endmodule

/* rtl/queue_entry_pkg.sv */
`include "frame_read_params.svh"

package queue_entry_pkg;

  // ====================
  // Frame control queue
  // ====================

  // One frame descriptor, 47 bits
  typedef struct packed {
    logic [`ADDR_W-1:0] start_addr;
    logic [`ZOOM_W-1:0] zoom;
    logic [`FLEN_W-1:0] frame_len;
    logic               tail;
    logic               bottom;
  } fcq_entry_t;

  // Capture side write port
  typedef struct packed {
    logic               valid;
    logic [`FNUM_W-1:0] fnum;
    fcq_entry_t         entry;
  } fcq_wr_t;

  // ====================
  // Buffer control queue
  // ====================

  // Descriptor as written by capture
  typedef struct packed {
    logic               video;
    logic               frame;
    logic               audio;
    logic [`FNUM_W-1:0] head_fnum;
    logic [`FNUM_W-1:0] top_fnum;
  } bcq_desc_t;

  // Stored entry, size is sampled at write time
  typedef struct packed {
    bcq_desc_t           desc;
    logic [`BSIZE_W-1:0] size;
  } bcq_entry_t;

endpackage

/* rtl/read_addr_gen.sv */
`timescale 1ns/10ps
`include "frame_read_params.svh"

module read_addr_gen (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        load_i,
  input  queue_entry_pkg::fcq_entry_t entry_i,
  input  logic                        mem_rd_cmd_i,
  input  logic                        mem_rd_vld_i,
  input  logic [2:0]                  type_i,
  output logic                        sof_o,
  output logic                        eof_o,
  output logic [`ADDR_W-1:0]          rd_addr_o,
  output logic [2:0]                  type_o,
  output logic                        addr_err_o
);

  localparam int BURST_BYTES = `MEM_BL * 4;

  logic [`FLEN_W-1:0] word_cnt;
  logic [`FLEN_W-1:0] last_word;
  logic [`ADDR_W-1:0] addr;

  // ====================
  // Word counter and sideband
  // ====================
  assign last_word = (entry_i.frame_len >> 2) - 1'b1;
  assign sof_o     = mem_rd_vld_i && (word_cnt == '0);
  assign eof_o     = mem_rd_vld_i && (word_cnt == last_word);

  always_ff @(posedge clk) begin
    if (rst) begin
      word_cnt <= '0;
    end else if (mem_rd_vld_i) begin
      word_cnt <= eof_o ? '0 : word_cnt + 1'b1;
    end
  end

  // Buffer type flags, one stage to ease timing
  always_ff @(posedge clk) begin
    type_o <= type_i;
  end

  // ====================
  // Burst address
  // ====================
  always_ff @(posedge clk) begin
    if (rst) begin
      addr <= '0;
    end else if (load_i) begin
      addr <= entry_i.start_addr;
    end else if (mem_rd_cmd_i) begin
      addr <= addr + `ADDR_W'(BURST_BYTES);
    end
  end

  always_ff @(posedge clk) begin
    rd_addr_o <= addr;
  end

  // Sticky flag for an unaligned frame start
  always_ff @(posedge clk) begin
    if (rst) begin
      addr_err_o <= 1'b0;
    end else if (load_i && entry_i.start_addr[`ALIGN_BITS-1:0] != '0) begin
      addr_err_o <= 1'b1;
    end
  end

endmodule

/* rtl/read_ctrl_pkg.sv */
package read_ctrl_pkg;

  // Playback controller states
  typedef enum logic [3:0] {
    IDLE,
    LOAD_HEAD,
    RD_FCQ,
    FCQ_AVAIL,
    RPT_DECIDE,
    READ_REPEAT,
    READ_NEXT,
    READ_WRAP,
    READ_LAST,
    BUF_DONE,
    DISCARD
  } play_state_e;

  // Per-word read sideband
  typedef struct packed {
    logic sof;
    logic eof;
    logic sob;
    logic eob;
    logic video;
    logic frame;
    logic audio;
  } rd_side_t;

endpackage

/* run_sim.sh */
#!/bin/sh
rm -f sim.log
verilator --binary --timing --top-module tb_mem_read_ctrl -f project.f -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* testbench/read_cases.txt */
// Header: frames rate full capturing restart video frame audio head top size
// Frame:  fnum start_addr zoom length tail bottom
4 1 0 0 1 1 0 0 0 0 58
0 1000 1 20 0 0
1 2000 2 10 0 0
2 3000 3 18 0 0
3 4000 4 10 1 0
4 2 0 0 1 0 1 0 6 4 40
6 10000 5 10 0 0
7 11000 6 14 0 1
4 12000 7 c 0 0
5 13000 8 10 1 0
2 0 1 0 1 1 1 0 0 0 8
0 1000 9 30 0 0
1 2000 a 8 1 0
2 3 0 1 0 0 0 1 8 8 1c
8 20000 b 10 0 0
9 21000 c c 1 0
1 1 0 0 1 1 0 1 a a 10
a 30040 d 10 1 0
0

/* testbench/tb_mem_read_ctrl.sv */
`timescale 1ns/10ps
`include "frame_read_params.svh"

module tb_mem_read_ctrl;

  logic clk = 1'b0;
  logic rst;
  logic bcq_wr_valid_i;
  logic bcq_wr_ready_o;
  logic capturing_i;
  logic buf_full_i;
  logic send_wr_i;
  logic disc_req_i;
  logic disc_ack_o;
  logic mem_rd_cmd_i;
  logic mem_rd_vld_i;
  logic frame_rdy_o;
  logic buf_avail_o;
  logic frm_avail_o;
  logic rpl_done_o;
  logic addr_err_o;
  logic [`RPT_W-1:0]          rpt_rate_i;
  logic [`ADDR_W-1:0]         rd_addr_o;
  logic [`ZOOM_W-1:0]         zoom_o;
  logic [`FLEN_W-1:0]         frame_len_o;
  logic [`BSIZE_W-1:0]        buf_size_o;
  queue_entry_pkg::fcq_wr_t   fcq_wr_i;
  queue_entry_pkg::bcq_desc_t bcq_wr_desc_i;
  read_ctrl_pkg::rd_side_t    rd_side_o;

  logic [31:0] case_mem [0:255];
  queue_entry_pkg::fcq_entry_t fcq_model [0:(1<<`FNUM_W)-1];
  int          exp_reads[$];
  logic [31:0] lfsr_state = 32'ha32af840;
  logic        err_exp = 1'b0;
  int          cycle_cnt = 0;
  int          cycle_limit = 100;

  mem_read_ctrl mem_read_ctrl_inst (.*);

  always #4 clk = ~clk;

  // Run limit grows with each case
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("ERROR timeout, the DUT stopped responding after %0d cycles", cycle_cnt);
      $display("sim failed");
      $fatal(1, "timeout");
    end
  end

  // Taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic report(input string name, input logic [63:0] exp, input logic [63:0] act);
    $display("MISMATCH %s expected %h actual %h", name, exp, act);
    $display("sim failed");
    $fatal(1, "check failed");
  endtask

  // ====================
  // Compare tasks
  // ====================
  task automatic check_side(input string name, input read_ctrl_pkg::rd_side_t exp,
                            input read_ctrl_pkg::rd_side_t act);
    if (act !== exp) report(name, 64'(exp), 64'(act));
  endtask

  task automatic check_frame(input string name, input queue_entry_pkg::fcq_entry_t exp,
                             input logic [`ZOOM_W-1:0] zoom, input logic [`FLEN_W-1:0] len);
    if (zoom !== exp.zoom) report({name, " zoom"}, 64'(exp.zoom), 64'(zoom));
    if (len !== exp.frame_len) report({name, " length"}, 64'(exp.frame_len), 64'(len));
  endtask

  task automatic check_addr(input string name, input logic [`ADDR_W-1:0] exp,
                            input logic [`ADDR_W-1:0] act);
    if (act !== exp) report(name, 64'(exp), 64'(act));
  endtask

  task automatic check_size(input string name, input logic [`BSIZE_W-1:0] exp,
                            input logic [`BSIZE_W-1:0] act);
    if (act !== exp) report(name, 64'(exp), 64'(act));
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) report(name, 64'(exp), 64'(act));
  endtask

  // Expected read order from the repeat, wrap and tail rules
  task automatic build_reads(input int head, input int top, input int rate);
    int f;
    int eff;
    int guard;
    f = head;
    eff = (rate == 0) ? 1 : rate;
    guard = 0;
    exp_reads.delete();
    forever begin
      for (int r = 0; r < eff; r++) exp_reads.push_back(f);
      if (fcq_model[f].tail) break;
      f = fcq_model[f].bottom ? top : (f + 1) % (1 << `FNUM_W);
      guard++;
      if (guard > 64) begin
        $display("ERROR frame chain from the head never reaches a tail frame");
        $display("sim failed");
        $fatal(1, "bad case data");
      end
    end
  endtask

  // ====================
  // Memory side playback
  // ====================
  task automatic play_buffer(input int head, input read_ctrl_pkg::rd_side_t type_side);
    int ri;
    int widx;
    int nw;
    int ncmd;
    logic nv;
    logic nc;
    logic gap;
    logic pend;
    logic [`ADDR_W-1:0] exp_addr;
    queue_entry_pkg::fcq_entry_t cur;
    read_ctrl_pkg::rd_side_t exp_side;
    ri = 0;
    widx = 0;
    ncmd = 0;
    nv = 1'b0;
    nc = 1'b0;
    gap = 1'b0;
    pend = 1'b0;
    cur = fcq_model[exp_reads[0]];
    nw = int'(cur.frame_len >> 2);
    while (ri < exp_reads.size()) begin
      @(posedge clk);
      mem_rd_vld_i <= nv;
      mem_rd_cmd_i <= nc;
      @(negedge clk);
      if (pend) check_addr("rd_addr after command", exp_addr, rd_addr_o);
      pend = 1'b0;
      // Read states end with the eof word
      if (gap) begin
        check_flag($sformatf("frame_rdy after read %0d", ri - 1), 1'b0, frame_rdy_o);
        gap = 1'b0;
      end
      if (mem_rd_cmd_i) begin
        exp_addr = cur.start_addr + `ADDR_W'(ncmd * `MEM_BL * 4);
        pend = 1'b1;
        ncmd++;
      end
      if (mem_rd_vld_i) begin
        check_flag($sformatf("rpl_done during read %0d", ri), 1'b0, rpl_done_o);
        exp_side = type_side;
        exp_side.sof = (widx == 0);
        exp_side.eof = (widx == nw - 1);
        exp_side.sob = exp_side.sof && (exp_reads[ri] == head);
        exp_side.eob = exp_side.eof && (ri == exp_reads.size() - 1);
        check_side($sformatf("sideband read %0d word %0d", ri, widx), exp_side, rd_side_o);
        if (widx == 0) check_frame($sformatf("frame at sof of read %0d", ri), cur,
                                   zoom_o, frame_len_o);
        widx++;
        if (widx == nw) begin
          ri++;
          widx = 0;
          ncmd = 0;
          gap = 1'b1;
          if (ri < exp_reads.size()) begin
            cur = fcq_model[exp_reads[ri]];
            nw = int'(cur.frame_len >> 2);
          end
        end
      end
      nv = 1'b0;
      nc = 1'b0;
      if (frame_rdy_o && !gap && ri < exp_reads.size()) begin
        lfsr_state = lfsr_next(lfsr_state);
        nv = lfsr_state[0];
        nc = !lfsr_state[0];
      end
    end
    @(posedge clk);
    mem_rd_vld_i <= 1'b0;
    mem_rd_cmd_i <= 1'b0;
  endtask

  task automatic run_case(input int base, input int num, output int next_base);
    int nfr;
    int fb;
    int words;
    queue_entry_pkg::fcq_wr_t wr;
    queue_entry_pkg::bcq_desc_t desc;
    read_ctrl_pkg::rd_side_t type_side;
    nfr = int'(case_mem[base]);
    desc = '{video: case_mem[base+5][0], frame: case_mem[base+6][0],
             audio: case_mem[base+7][0], head_fnum: case_mem[base+8][`FNUM_W-1:0],
             top_fnum: case_mem[base+9][`FNUM_W-1:0]};
    @(posedge clk);
    rpt_rate_i  <= case_mem[base+1][`RPT_W-1:0];
    buf_full_i  <= case_mem[base+2][0];
    capturing_i <= case_mem[base+3][0];
    send_wr_i   <= case_mem[base+4][0];
    @(posedge clk);
    send_wr_i <= 1'b0;
    repeat (2) @(posedge clk);
    for (int i = 0; i < nfr; i++) begin
      fb = base + 11 + 6 * i;
      wr = '{valid: 1'b1, fnum: case_mem[fb][`FNUM_W-1:0],
             entry: '{start_addr: case_mem[fb+1][`ADDR_W-1:0],
                      zoom: case_mem[fb+2][`ZOOM_W-1:0],
                      frame_len: case_mem[fb+3][`FLEN_W-1:0],
                      tail: case_mem[fb+4][0], bottom: case_mem[fb+5][0]}};
      fcq_model[wr.fnum] = wr.entry;
      @(posedge clk);
      fcq_wr_i <= wr;
      @(posedge clk);
      fcq_wr_i <= '0;
      @(negedge clk);
      check_flag($sformatf("case %0d frm_avail", num), !wr.entry.tail, frm_avail_o);
    end
    build_reads(int'(desc.head_fnum), int'(desc.top_fnum), int'(case_mem[base+1]));
    words = 0;
    foreach (exp_reads[i]) words += int'(fcq_model[exp_reads[i]].frame_len >> 2);
    cycle_limit += 200 + 4 * words;
    @(posedge clk);
    bcq_wr_valid_i <= 1'b1;
    bcq_wr_desc_i  <= desc;
    @(posedge clk);
    bcq_wr_valid_i <= 1'b0;
    @(negedge clk);
    check_size($sformatf("case %0d buf_size", num), case_mem[base+10], buf_size_o);
    type_side = '{sof: 1'b0, eof: 1'b0, sob: 1'b0, eob: 1'b0,
                  video: desc.video, frame: desc.frame, audio: desc.audio};
    play_buffer(int'(desc.head_fnum), type_side);
    foreach (exp_reads[i]) begin
      if (fcq_model[exp_reads[i]].start_addr[`ALIGN_BITS-1:0] != '0) err_exp = 1'b1;
    end
    @(negedge clk);
    check_flag($sformatf("case %0d frame_rdy in done", num), 1'b0, frame_rdy_o);
    check_flag($sformatf("case %0d rpl_done at eob", num), 1'b1, rpl_done_o);
    check_flag($sformatf("case %0d buf_avail", num), 1'b1, buf_avail_o);
    check_flag($sformatf("case %0d addr_err", num), err_exp, addr_err_o);
    // Discard handshake
    @(posedge clk);
    disc_req_i <= 1'b1;
    @(negedge clk);
    while (!disc_ack_o) @(negedge clk);
    @(posedge clk);
    disc_req_i <= 1'b0;
    @(negedge clk);
    check_flag($sformatf("case %0d disc_ack one cycle", num), 1'b0, disc_ack_o);
    check_flag($sformatf("case %0d rpl_done after ack", num), 1'b0, rpl_done_o);
    @(negedge clk);
    check_flag($sformatf("case %0d buf_avail after ack", num), 1'b0, buf_avail_o);
    next_base = base + 11 + 6 * nfr;
  endtask

  // ====================
  // Main sequence
  // ====================
  initial begin
    int ptr;
    int num;
    rst = 1'b1;
    rpt_rate_i = '0;
    fcq_wr_i = '0;
    bcq_wr_valid_i = 1'b0;
    bcq_wr_desc_i = '0;
    capturing_i = 1'b0;
    buf_full_i = 1'b0;
    send_wr_i = 1'b0;
    disc_req_i = 1'b0;
    mem_rd_cmd_i = 1'b0;
    mem_rd_vld_i = 1'b0;
    $readmemh("testbench/read_cases.txt", case_mem);
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    ptr = 0;
    num = 0;
    while (case_mem[ptr] != 32'h0) begin
      run_case(ptr, num, ptr);
      num++;
    end
    // BCQ fills with no pops
    cycle_limit += 200;
    for (int i = 0; i < `BCQ_DEPTH; i++) begin
      @(posedge clk);
      bcq_wr_valid_i <= 1'b1;
      @(negedge clk);
      check_flag($sformatf("bcq ready before write %0d", i), 1'b1, bcq_wr_ready_o);
    end
    @(posedge clk);
    bcq_wr_valid_i <= 1'b0;
    @(negedge clk);
    check_flag("bcq ready when full", 1'b0, bcq_wr_ready_o);
    $display("sim passed");
    $finish;
  end

endmodule
